// File: flist.f
+incdir+.
ifetch_pkg.sv
l0_instruction_cache.sv
l1_instruction_cache.sv
wb_arbiter.sv
imem_wb.sv
ifetch_top.sv
tb_ifetch.sv

// File: ifetch_macros.svh
// size constants for the instruction fetch subsystem, included by the package, RTL and testbench
`ifndef IFETCH_MACROS_SVH
`define IFETCH_MACROS_SVH

// fetch address width
`define PC_SIZE 32

// one cache line holds four instruction words
`define LINE_BYTES 16
`define LINE_BITS 128
`define WORD_BITS 32

// direct-mapped set counts
`define L0_SETS 8
`define L1_SETS 32

// instruction memory depth in words, 1 KiB
`define MEM_WORDS 256

`endif

// File: ifetch_pkg.sv
// line, tag entry and L1 state types shared by the fetch caches and the testbench
`default_nettype none

`include "ifetch_macros.svh"

package ifetch_pkg;

  // word 0 sits in the low 32 bits
  typedef logic [`LINE_BITS-1:0] line_t;

  // L0 tag entry, 25 tag bits with 8 sets and 16-byte lines
  typedef struct packed {
    logic valid;
    logic [`PC_SIZE-$clog2(`L0_SETS)-$clog2(`LINE_BYTES)-1:0] tag;
  } l0_tag_t;

  // L1 tag entry, 23 tag bits with 32 sets
  typedef struct packed {
    logic valid;
    logic [`PC_SIZE-$clog2(`L1_SETS)-$clog2(`LINE_BYTES)-1:0] tag;
  } l1_tag_t;

  // L1 controller states
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    LOOKUP = 2'd1,
    REFILL = 2'd2,
    FILL   = 2'd3
  } l1_state_t;

endpackage

`default_nettype wire

// File: ifetch_top.sv
// instruction fetch top level, joins fetch port, loader port, both caches, arbiter and memory
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_macros.svh"

module ifetch_top
  import ifetch_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  flush,
  // fetch port
  input  wire logic                  fetch_req,
  input  wire logic [`PC_SIZE-1:0]   fetch_pc,
  output logic                       fetch_ack,
  output line_t                      fetch_line,
  // loader port, wishbone master side
  input  wire logic                  ld_cyc,
  input  wire logic                  ld_stb,
  input  wire logic                  ld_we,
  input  wire logic [`PC_SIZE-1:0]   ld_adr,
  input  wire logic [`WORD_BITS-1:0] ld_dat_w,
  output logic [`WORD_BITS-1:0]      ld_dat_r,
  output logic                       ld_ack
);

  logic                  l0_hit;
  logic                  fill_valid;
  logic [`PC_SIZE-1:0]   fill_pc;
  line_t                 fill_line;

  // refill master
  logic                  rf_cyc;
  logic                  rf_stb;
  logic                  rf_we;
  logic [`PC_SIZE-1:0]   rf_adr;
  logic [`WORD_BITS-1:0] rf_dat_w;
  logic [`WORD_BITS-1:0] rf_dat_r;
  logic                  rf_ack;

  // memory slave
  logic                  s_cyc;
  logic                  s_stb;
  logic                  s_we;
  logic [`PC_SIZE-1:0]   s_adr;
  logic [`WORD_BITS-1:0] s_dat_w;
  logic [`WORD_BITS-1:0] s_dat_r;
  logic                  s_ack;

  assign fetch_ack = l0_hit;

  l0_instruction_cache u_l0 (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .fetch_req(fetch_req), .fetch_pc(fetch_pc),
    .fill_valid(fill_valid), .fill_pc(fill_pc), .fill_line(fill_line),
    .l0_hit(l0_hit), .cache_line(fetch_line)
  );

  l1_instruction_cache u_l1 (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .fetch_req(fetch_req), .fetch_pc(fetch_pc), .l0_hit(l0_hit),
    .fill_valid(fill_valid), .fill_pc(fill_pc), .fill_line(fill_line),
    .wb_cyc(rf_cyc), .wb_stb(rf_stb), .wb_we(rf_we), .wb_adr(rf_adr),
    .wb_dat_w(rf_dat_w), .wb_dat_r(rf_dat_r), .wb_ack(rf_ack)
  );

  wb_arbiter u_arb (
    .clk(clk), .rst_n(rst_n),
    .m0_cyc(ld_cyc), .m0_stb(ld_stb), .m0_we(ld_we), .m0_adr(ld_adr),
    .m0_dat_w(ld_dat_w), .m0_dat_r(ld_dat_r), .m0_ack(ld_ack),
    .m1_cyc(rf_cyc), .m1_stb(rf_stb), .m1_we(rf_we), .m1_adr(rf_adr),
    .m1_dat_w(rf_dat_w), .m1_dat_r(rf_dat_r), .m1_ack(rf_ack),
    .s_cyc(s_cyc), .s_stb(s_stb), .s_we(s_we), .s_adr(s_adr),
    .s_dat_w(s_dat_w), .s_dat_r(s_dat_r), .s_ack(s_ack)
  );

  imem_wb u_mem (
    .clk(clk), .rst_n(rst_n),
    .wb_cyc(s_cyc), .wb_stb(s_stb), .wb_we(s_we), .wb_adr(s_adr),
    .wb_dat_w(s_dat_w), .wb_dat_r(s_dat_r), .wb_ack(s_ack)
  );

endmodule

`default_nettype wire

// File: imem_wb.sv
// word-wide instruction memory behind a Wishbone classic slave port, registered ack
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_macros.svh"

module imem_wb (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  wb_cyc,
  input  wire logic                  wb_stb,
  input  wire logic                  wb_we,
  input  wire logic [`PC_SIZE-1:0]   wb_adr,
  input  wire logic [`WORD_BITS-1:0] wb_dat_w,
  output logic [`WORD_BITS-1:0]      wb_dat_r,
  output logic                       wb_ack
);

  localparam int ADDR_BITS = $clog2(`MEM_WORDS);

  logic [`WORD_BITS-1:0] mem [`MEM_WORDS];
  logic [ADDR_BITS-1:0]  word_index;
  logic                  access;

  assign word_index = wb_adr[ADDR_BITS+1:2]; // bits 9:2
  // no new access in the ack cycle, so a held strobe is not acked twice
  assign access = wb_cyc & wb_stb & ~wb_ack;

  always_ff @(posedge clk) begin
    if (!rst_n) wb_ack <= 1'b0;
    else        wb_ack <= access;
  end

  always_ff @(posedge clk) begin
    if (access) begin
      if (wb_we) mem[word_index] <= wb_dat_w;
      wb_dat_r <= mem[word_index]; // valid with ack
    end
  end

endmodule

`default_nettype wire

// File: l0_instruction_cache.sv
// zero-latency L0 instruction cache, combinational lookup with a clocked fill from the L1
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_macros.svh"

module l0_instruction_cache
  import ifetch_pkg::*;
(
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                flush,
  input  wire logic                fetch_req,
  input  wire logic [`PC_SIZE-1:0] fetch_pc,   // address looked up this cycle
  input  wire logic                fill_valid, // one-cycle write strobe from the L1
  input  wire logic [`PC_SIZE-1:0] fill_pc,
  input  wire line_t               fill_line,
  output logic                     l0_hit,
  output line_t                    cache_line
);

  localparam int OFFSET_BITS = $clog2(`LINE_BYTES);
  localparam int INDEX_BITS  = $clog2(`L0_SETS);
  localparam int TAG_BITS    = `PC_SIZE - INDEX_BITS - OFFSET_BITS;

  l0_tag_t tag_array  [`L0_SETS];
  line_t   data_array [`L0_SETS];

  logic [INDEX_BITS-1:0] rd_index;
  logic [TAG_BITS-1:0]   rd_tag;
  logic [INDEX_BITS-1:0] wr_index;
  logic [TAG_BITS-1:0]   wr_tag;

  assign rd_index = fetch_pc[OFFSET_BITS +: INDEX_BITS];
  assign rd_tag   = fetch_pc[`PC_SIZE-1 -: TAG_BITS];
  assign wr_index = fill_pc[OFFSET_BITS +: INDEX_BITS];
  assign wr_tag   = fill_pc[`PC_SIZE-1 -: TAG_BITS];

  // same-cycle answer
  assign l0_hit = fetch_req & tag_array[rd_index].valid & (tag_array[rd_index].tag == rd_tag);
  assign cache_line = data_array[rd_index];

  // valid bits and tags; a fill on the flush edge still lands
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `L0_SETS; i++) begin
        tag_array[i].valid <= 1'b0;
      end
    end else begin
      if (flush) begin
        for (int i = 0; i < `L0_SETS; i++) begin
          tag_array[i].valid <= 1'b0;
        end
      end
      if (fill_valid) begin
        tag_array[wr_index].valid <= 1'b1;
        tag_array[wr_index].tag   <= wr_tag;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill_valid) data_array[wr_index] <= fill_line; // line payload
  end

endmodule

`default_nettype wire

// File: l1_instruction_cache.sv
// L1 instruction cache, handles L0 misses and refills lines over a Wishbone master port
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_macros.svh"

module l1_instruction_cache
  import ifetch_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 flush,
  input  wire logic                 fetch_req,
  input  wire logic [`PC_SIZE-1:0]  fetch_pc,
  input  wire logic                 l0_hit,
  output logic                      fill_valid,
  output logic [`PC_SIZE-1:0]       fill_pc,
  output line_t                     fill_line,
  // wishbone master, read only
  output logic                      wb_cyc,
  output logic                      wb_stb,
  output logic                      wb_we,
  output logic [`PC_SIZE-1:0]       wb_adr,
  output logic [`WORD_BITS-1:0]     wb_dat_w,
  input  wire logic [`WORD_BITS-1:0] wb_dat_r,
  input  wire logic                 wb_ack
);

  localparam int OFFSET_BITS   = $clog2(`LINE_BYTES);
  localparam int INDEX_BITS    = $clog2(`L1_SETS);
  localparam int TAG_BITS      = `PC_SIZE - INDEX_BITS - OFFSET_BITS;
  localparam int WORDS         = `LINE_BITS / `WORD_BITS;
  localparam int WORD_SEL_BITS = $clog2(WORDS);
  localparam int BYTE_SEL_BITS = OFFSET_BITS - WORD_SEL_BITS;

  l1_state_t state;

  l1_tag_t tag_array  [`L1_SETS];
  line_t   data_array [`L1_SETS];

  logic [`PC_SIZE-1:0]      pc_q;     // line-aligned miss address
  l1_tag_t                  tag_q;    // registered tag read
  line_t                    line_buf; // registered data read, then refill assembly
  logic [WORD_SEL_BITS-1:0] word_cnt;

  logic [INDEX_BITS-1:0] req_index;
  logic [INDEX_BITS-1:0] line_index;
  logic [TAG_BITS-1:0]   line_tag;
  logic                  miss_req;
  logic                  lookup_hit;

  assign req_index  = fetch_pc[OFFSET_BITS +: INDEX_BITS];
  assign line_index = pc_q[OFFSET_BITS +: INDEX_BITS];
  assign line_tag   = pc_q[`PC_SIZE-1 -: TAG_BITS];
  assign miss_req   = fetch_req & ~l0_hit;
  // a flush during the lookup turns the registered hit into a miss
  assign lookup_hit = tag_q.valid & ~flush & (tag_q.tag == line_tag);

  // fill the L0 straight from LOOKUP on a hit, or after a refill
  assign fill_valid = ((state == LOOKUP) & lookup_hit) | (state == FILL);
  assign fill_pc    = pc_q;
  assign fill_line  = line_buf;

  // cyc and stb stay up for the whole refill, the slave spaces its acks
  assign wb_cyc   = (state == REFILL);
  assign wb_stb   = (state == REFILL);
  assign wb_we    = 1'b0;
  assign wb_dat_w = '0;
  assign wb_adr   = {pc_q[`PC_SIZE-1:OFFSET_BITS], word_cnt, {BYTE_SEL_BITS{1'b0}}};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= IDLE;
      word_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (miss_req) state <= LOOKUP;
        end
        LOOKUP: begin
          word_cnt <= '0;
          state    <= lookup_hit ? IDLE : REFILL;
        end
        REFILL: begin
          if (wb_ack) begin
            word_cnt <= word_cnt + 1'b1;
            if (word_cnt == '1) state <= FILL; // last word in
          end
        end
        FILL: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // valid bits; a refill in flight still writes after a flush
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `L1_SETS; i++) begin
        tag_array[i].valid <= 1'b0;
      end
    end else begin
      if (flush) begin
        for (int i = 0; i < `L1_SETS; i++) begin
          tag_array[i].valid <= 1'b0;
        end
      end
      if (state == FILL) begin
        tag_array[line_index].valid <= 1'b1;
        tag_array[line_index].tag   <= line_tag;
      end
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      IDLE: begin
        if (miss_req) begin
          pc_q        <= {fetch_pc[`PC_SIZE-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
          tag_q.tag   <= tag_array[req_index].tag;
          tag_q.valid <= tag_array[req_index].valid & ~flush; // flush on this edge wins
          line_buf    <= data_array[req_index];
        end
      end
      REFILL: begin
        if (wb_ack) line_buf[word_cnt*`WORD_BITS +: `WORD_BITS] <= wb_dat_r;
      end
      FILL: data_array[line_index] <= line_buf;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: tb_ifetch.sv
// table-driven testbench for ifetch_top, checks loader access, cache refill, hits, conflicts and flush
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_macros.svh"

module tb_ifetch
  import ifetch_pkg::*;
();

  typedef enum logic [2:0] {LOAD_WR, LOAD_RD, FETCH, FLUSH, FETCH_LD} op_t;

  // FETCH_LD starts a cold fetch and writes ld_adr through the loader while it refills
  typedef struct packed {
    op_t                   op;
    logic [`PC_SIZE-1:0]   addr;
    logic [`WORD_BITS-1:0] data;
    logic                  hit;   // zero-cycle ack expected
    logic [`PC_SIZE-1:0]   ld_adr;
  } entry_t;

  localparam int NUM_ENTRIES = 19;
  localparam int TIMEOUT     = NUM_ENTRIES * 40 + `MEM_WORDS * 3 + 16;

  logic                  clk;
  logic                  rst_n;
  logic                  flush;
  logic                  fetch_req;
  logic [`PC_SIZE-1:0]   fetch_pc;
  logic                  fetch_ack;
  line_t                 fetch_line;
  logic                  ld_cyc;
  logic                  ld_stb;
  logic                  ld_we;
  logic [`PC_SIZE-1:0]   ld_adr;
  logic [`WORD_BITS-1:0] ld_dat_w;
  logic [`WORD_BITS-1:0] ld_dat_r;
  logic                  ld_ack;

  logic [`WORD_BITS-1:0] ref_mem [`MEM_WORDS]; // mirror of every loader write
  entry_t                tbl [NUM_ENTRIES];
  integer                seed;
  int                    errors;
  int                    checks;
  int                    cycles;
  l1_state_t             l1_state;

  ifetch_top DUT (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .fetch_req(fetch_req), .fetch_pc(fetch_pc),
    .fetch_ack(fetch_ack), .fetch_line(fetch_line),
    .ld_cyc(ld_cyc), .ld_stb(ld_stb), .ld_we(ld_we), .ld_adr(ld_adr),
    .ld_dat_w(ld_dat_w), .ld_dat_r(ld_dat_r), .ld_ack(ld_ack)
  );

  always #10 clk = ~clk;

  // watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      l1_state = DUT.u_l1.state;
      $display("timeout: no response after %0d cycles, L1 controller stuck in %s",
               cycles, l1_state.name());
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check(input logic [`LINE_BITS-1:0] actual,
                       input logic [`LINE_BITS-1:0] expected, input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0t: %s, got %h expected %h", $time, what, actual, expected);
    end
  endtask

  // one loader access, waits for ack
  task automatic ld_access(input logic we, input logic [`PC_SIZE-1:0] adr,
                           input logic [`WORD_BITS-1:0] dat, output logic [`WORD_BITS-1:0] rd);
    @(negedge clk);
    ld_cyc   = 1'b1;
    ld_stb   = 1'b1;
    ld_we    = we;
    ld_adr   = adr;
    ld_dat_w = dat;
    do @(negedge clk); while (!ld_ack);
    rd     = ld_dat_r; // valid with ack
    ld_cyc = 1'b0;
    ld_stb = 1'b0;
    ld_we  = 1'b0;
  endtask

  // four reference words of the line holding pc, word 0 lowest
  function automatic line_t expected_line(input logic [`PC_SIZE-1:0] pc);
    line_t l;
    int    base;
    base = pc[9:4] * 4;
    for (int w = 0; w < 4; w++) begin
      l[w*`WORD_BITS +: `WORD_BITS] = ref_mem[base + w];
    end
    return l;
  endfunction

  task automatic do_fetch(input logic [`PC_SIZE-1:0] pc, input logic exp_hit);
    line_t exp;
    @(negedge clk);
    fetch_req = 1'b1;
    fetch_pc  = pc;
    #2;
    check(fetch_ack, exp_hit, $sformatf("same-cycle ack for pc %h", pc));
    while (!fetch_ack) @(negedge clk);
    exp = expected_line(pc);
    check(fetch_line, exp, $sformatf("line for pc %h", pc));
    fetch_req = 1'b0;
  endtask

  function automatic entry_t make_entry(input op_t op, input logic [`PC_SIZE-1:0] addr,
                                        input logic [`WORD_BITS-1:0] data, input logic hit,
                                        input logic [`PC_SIZE-1:0] ld_a);
    entry_t e;
    e.op     = op;
    e.addr   = addr;
    e.data   = data;
    e.hit    = hit;
    e.ld_adr = ld_a;
    return e;
  endfunction

  task automatic fill_table();
    tbl[0]  = make_entry(LOAD_WR,  32'h300, 32'h1111_2222, 1'b0, 0);
    tbl[1]  = make_entry(LOAD_WR,  32'h304, 32'h3333_4444, 1'b0, 0);
    tbl[2]  = make_entry(LOAD_RD,  32'h300, 0, 1'b0, 0);
    tbl[3]  = make_entry(LOAD_RD,  32'h304, 0, 1'b0, 0);
    tbl[4]  = make_entry(FETCH,    32'h040, 0, 1'b0, 0);  // cold, L1 refill
    tbl[5]  = make_entry(FETCH,    32'h040, 0, 1'b1, 0);  // L0 hit
    tbl[6]  = make_entry(FETCH,    32'h04c, 0, 1'b1, 0);  // same line
    tbl[7]  = make_entry(FETCH,    32'h0c0, 0, 1'b0, 0);  // same L0 set, new tag
    tbl[8]  = make_entry(FETCH,    32'h040, 0, 1'b0, 0);  // back from the L1
    tbl[9]  = make_entry(FETCH,    32'h044, 0, 1'b1, 0);
    tbl[10] = make_entry(LOAD_WR,  32'h040, 32'hdead_beef, 1'b0, 0);
    tbl[11] = make_entry(LOAD_WR,  32'h048, 32'h0bad_f00d, 1'b0, 0);
    tbl[12] = make_entry(FLUSH,    0, 0, 1'b0, 0);
    tbl[13] = make_entry(FETCH,    32'h040, 0, 1'b0, 0);  // rewritten line after flush
    tbl[14] = make_entry(FETCH,    32'h048, 0, 1'b1, 0);
    tbl[15] = make_entry(FETCH_LD, 32'h200, 32'hcafe_0001, 1'b0, 32'h3f0);
    tbl[16] = make_entry(FETCH,    32'h200, 0, 1'b1, 0);
    tbl[17] = make_entry(LOAD_RD,  32'h3f0, 0, 1'b0, 0);
    tbl[18] = make_entry(FETCH,    32'h300, 0, 1'b0, 0);
  endtask

  initial begin
    entry_t                e;
    logic [`WORD_BITS-1:0] rd;
    clk       = 1'b0;
    rst_n     = 1'b0;
    flush     = 1'b0;
    fetch_req = 1'b0;
    fetch_pc  = '0;
    ld_cyc    = 1'b0;
    ld_stb    = 1'b0;
    ld_we     = 1'b0;
    ld_adr    = '0;
    ld_dat_w  = '0;
    seed      = 76;
    errors    = 0;
    checks    = 0;
    cycles    = 0;

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // program image through the loader
    for (int i = 0; i < `MEM_WORDS; i++) begin
      ref_mem[i] = $random(seed);
      ld_access(1'b1, i * 4, ref_mem[i], rd);
    end

    fill_table();
    for (int n = 0; n < NUM_ENTRIES; n++) begin
      e = tbl[n];
      case (e.op)
        LOAD_WR: begin
          ld_access(1'b1, e.addr, e.data, rd);
          ref_mem[e.addr[9:2]] = e.data;
        end
        LOAD_RD: begin
          ld_access(1'b0, e.addr, '0, rd);
          check(rd, ref_mem[e.addr[9:2]], $sformatf("loader read at %h", e.addr));
        end
        FETCH: do_fetch(e.addr, e.hit);
        FLUSH: begin
          @(negedge clk);
          flush = 1'b1;
          @(negedge clk);
          flush = 1'b0;
        end
        FETCH_LD: begin
          fork
            do_fetch(e.addr, e.hit);
            begin
              repeat (3) @(negedge clk); // refill owns the bus by now
              ld_access(1'b1, e.ld_adr, e.data, rd);
              ref_mem[e.ld_adr[9:2]] = e.data;
              ld_access(1'b0, e.ld_adr, '0, rd);
              check(rd, e.data, $sformatf("read-back during refill at %h", e.ld_adr));
            end
          join
        end
        default: ;
      endcase
    end

    repeat (2) @(negedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: wb_arbiter.sv
// two-master Wishbone classic arbiter, loader has priority, grant locked while the owner holds cyc
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_macros.svh"

module wb_arbiter (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  // master 0, loader
  input  wire logic                  m0_cyc,
  input  wire logic                  m0_stb,
  input  wire logic                  m0_we,
  input  wire logic [`PC_SIZE-1:0]   m0_adr,
  input  wire logic [`WORD_BITS-1:0] m0_dat_w,
  output logic [`WORD_BITS-1:0]      m0_dat_r,
  output logic                       m0_ack,
  // master 1, L1 refill
  input  wire logic                  m1_cyc,
  input  wire logic                  m1_stb,
  input  wire logic                  m1_we,
  input  wire logic [`PC_SIZE-1:0]   m1_adr,
  input  wire logic [`WORD_BITS-1:0] m1_dat_w,
  output logic [`WORD_BITS-1:0]      m1_dat_r,
  output logic                       m1_ack,
  // slave side
  output logic                       s_cyc,
  output logic                       s_stb,
  output logic                       s_we,
  output logic [`PC_SIZE-1:0]        s_adr,
  output logic [`WORD_BITS-1:0]      s_dat_w,
  input  wire logic [`WORD_BITS-1:0] s_dat_r,
  input  wire logic                  s_ack
);

  logic locked; // a cycle is in progress
  logic owner;  // 0 loader, 1 refill
  logic sel;

  // free bus goes to master 0 whenever it asks
  assign sel = locked ? owner : ~m0_cyc;

  assign s_cyc   = sel ? m1_cyc   : m0_cyc;
  assign s_stb   = sel ? m1_stb   : m0_stb;
  assign s_we    = sel ? m1_we    : m0_we;
  assign s_adr   = sel ? m1_adr   : m0_adr;
  assign s_dat_w = sel ? m1_dat_w : m0_dat_w;

  assign m0_ack   = s_ack & ~sel;
  assign m1_ack   = s_ack & sel;
  assign m0_dat_r = s_dat_r;
  assign m1_dat_r = s_dat_r;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      locked <= 1'b0;
      owner  <= 1'b0;
    end else begin
      locked <= s_cyc; // released once the owner drops cyc
      owner  <= sel;
    end
  end

endmodule

`default_nettype wire
